// ==== Bender.yml ====
package:
  name: rename_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rename_pkg.sv
      - map_table.sv
      - retire_map.sv
      - free_list.sv
      - recovery_fsm.sv
      - rename_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rename_unit.sv

// ==== build.f ====
+incdir+.
rename_pkg.sv
map_table.sv
retire_map.sv
free_list.sv
recovery_fsm.sv
rename_unit.sv
tb_rename_unit.sv

// ==== free_list.sv ====
/*
 * Free list of physical tags.
 * Circular queue with one write pointer and two read pointers.
 * The speculative pointer hands out tags at dispatch, the committed
 * pointer follows retire, and a restore rewinds the speculative
 * pointer so that squashed allocations are free again.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module free_list
	import rename_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic [1:0] alloc_count,
	input retire_t retire [2],
	input wire logic restore,
	output logic [`PR_BITS-1:0] free_pr [2],
	output logic [`AR_BITS:0] free_count
);

	// one extra wrap bit tells full from empty.
	localparam int PTR_BITS = $clog2(`FREE_DEPTH) + 1;
	localparam int IDX_BITS = PTR_BITS - 1;

	logic [`PR_BITS-1:0] fifo_q [`FREE_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr_q;
	logic [PTR_BITS-1:0] spec_ptr_q;
	logic [PTR_BITS-1:0] commit_ptr_q;

	logic ret0;
	logic ret1;
	logic [PTR_BITS-1:0] ret_count;
	logic [PTR_BITS-1:0] wr_ptr_1;
	logic [PTR_BITS-1:0] spec_ptr_1;

	assign ret0 = retire[0].valid;
	assign ret1 = retire[0].valid && retire[1].valid;
	assign ret_count = PTR_BITS'(ret0) + PTR_BITS'(ret1);

	assign wr_ptr_1 = wr_ptr_q + 1'b1;
	assign spec_ptr_1 = spec_ptr_q + 1'b1;

	// oldest two free tags are the candidates.
	assign free_pr[0] = fifo_q[spec_ptr_q[IDX_BITS-1:0]];
	assign free_pr[1] = fifo_q[spec_ptr_1[IDX_BITS-1:0]];

	assign free_count = wr_ptr_q - spec_ptr_q;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `FREE_DEPTH; i++)
				fifo_q[i] <= `PR_BITS'(`ARCH_REGS + i); // tags above the identity map.
			wr_ptr_q <= PTR_BITS'(`FREE_DEPTH);
			spec_ptr_q <= '0;
			commit_ptr_q <= '0;
		end
		else
		begin
			if (ret0)
				fifo_q[wr_ptr_q[IDX_BITS-1:0]] <= retire[0].told;
			if (ret1)
				fifo_q[wr_ptr_1[IDX_BITS-1:0]] <= retire[1].told;
			wr_ptr_q <= wr_ptr_q + ret_count;
			commit_ptr_q <= commit_ptr_q + ret_count;
			if (restore)
				spec_ptr_q <= commit_ptr_q + ret_count; // includes this cycle's retire.
			else
				spec_ptr_q <= spec_ptr_q + PTR_BITS'(alloc_count);
		end
	end

	a_alloc_in_range: assert property (
		@(posedge clock) disable iff (reset)
		(PTR_BITS+1)'(alloc_count) <= (PTR_BITS+1)'(free_count))
		else $error("allocation beyond free count");

	// a retiring op was allocated earlier, so the queue has room for its told.
	a_push_not_full: assert property (
		@(posedge clock) disable iff (reset)
		(PTR_BITS+1)'(free_count) + (PTR_BITS+1)'(ret_count) <= `FREE_DEPTH)
		else $error("free queue push while full");

endmodule

`default_nettype wire

// ==== map_table.sv ====
/*
 * Speculative map table.
 * Maps architectural to physical registers with a ready bit each,
 * renames two instructions per cycle with bypass inside the group,
 * wakes registers from the broadcast ports and takes one restored
 * entry per cycle from the recovery walk.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table
	import rename_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input rename_req_t req [2],
	input wire logic accept,
	input wire logic [`PR_BITS-1:0] free_pr [2],
	input cdb_t cdb [`CDB_PORTS],
	input wire logic walk_en,
	input wire logic [`AR_BITS-1:0] walk_idx,
	input wire logic [`PR_BITS-1:0] walk_pr,
	output rename_resp_t resp [2]
);

	logic [`PR_BITS-1:0] map_q [`ARCH_REGS];
	logic [`ARCH_REGS-1:0] ready_q;
	logic [`ARCH_REGS-1:0] ready_d;

	logic hit_a1; // slot 1 source a is slot 0 dest.
	logic hit_b1;
	logic same_dest;
	logic wr0;
	logic wr1;

	assign hit_a1 = req[0].valid && (req[1].src_a == req[0].dest);
	assign hit_b1 = req[0].valid && (req[1].src_b == req[0].dest);
	assign same_dest = req[0].valid && (req[1].dest == req[0].dest);

	assign wr0 = accept; // accept already implies slot 0 valid.
	assign wr1 = accept && req[1].valid;

	// slot 0 sees the table as it stands.
	always_comb
	begin
		resp[0].pr_a = map_q[req[0].src_a];
		resp[0].ready_a = !req[0].use_a || ready_q[req[0].src_a];
		resp[0].pr_b = map_q[req[0].src_b];
		resp[0].ready_b = !req[0].use_b || ready_q[req[0].src_b];
		resp[0].pr_dest = free_pr[0];
		resp[0].pr_told = map_q[req[0].dest];
	end

	// slot 1 takes slot 0's new tag where it overlaps.
	always_comb
	begin
		if (hit_a1)
		begin
			resp[1].pr_a = free_pr[0];
			resp[1].ready_a = !req[1].use_a; // producer not yet issued.
		end
		else
		begin
			resp[1].pr_a = map_q[req[1].src_a];
			resp[1].ready_a = !req[1].use_a || ready_q[req[1].src_a];
		end
		if (hit_b1)
		begin
			resp[1].pr_b = free_pr[0];
			resp[1].ready_b = !req[1].use_b;
		end
		else
		begin
			resp[1].pr_b = map_q[req[1].src_b];
			resp[1].ready_b = !req[1].use_b || ready_q[req[1].src_b];
		end
		resp[1].pr_dest = free_pr[1];
		resp[1].pr_told = same_dest ? free_pr[0] : map_q[req[1].dest];
	end

	// wake-up first, then dispatch clears on top.
	always_comb
	begin
		ready_d = ready_q;
		if (walk_en)
		begin
			ready_d[walk_idx] = 1'b1; // restored tags hold committed values.
		end
		else
		begin
			for (int p = 0; p < `CDB_PORTS; p++)
			begin
				if (cdb[p].valid && (map_q[cdb[p].ar] == cdb[p].pr))
					ready_d[cdb[p].ar] = 1'b1;
			end
			if (wr0)
				ready_d[req[0].dest] = 1'b0;
			if (wr1)
				ready_d[req[1].dest] = 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `ARCH_REGS; i++)
				map_q[i] <= `PR_BITS'(i); // identity mapping.
			ready_q <= '1;
		end
		else
		begin
			ready_q <= ready_d;
			if (walk_en)
			begin
				map_q[walk_idx] <= walk_pr;
			end
			else
			begin
				if (wr0)
					map_q[req[0].dest] <= free_pr[0];
				if (wr1)
					map_q[req[1].dest] <= free_pr[1]; // slot 1 wins on equal dest.
			end
		end
	end

	// the walk owns the table; dispatch must be held off for all of it.
	a_no_accept_in_walk: assert property (
		@(posedge clock) disable iff (reset) !(accept && walk_en))
		else $error("dispatch accepted during recovery walk");

endmodule

`default_nettype wire

// ==== recovery_fsm.sv ====
/*
 * Recovery sequencer.
 * On a misprediction it rewinds the free list and then copies the
 * retired map into the map table, one entry per cycle, holding off
 * dispatch until the last entry is written.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module recovery_fsm
	import rename_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire logic recover,
	output logic walk_en,
	output logic [`AR_BITS-1:0] walk_idx,
	output logic restore,
	output logic recovering
);

	recover_state_t state_q;
	logic [`AR_BITS-1:0] idx_q;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state_q <= RECOVER_IDLE;
			idx_q <= '0;
		end
		else
		begin
			case (state_q)
				RECOVER_IDLE:
				begin
					if (recover)
					begin
						state_q <= RECOVER_WALK;
						idx_q <= '0;
					end
				end
				RECOVER_WALK:
				begin
					if (recover)
						idx_q <= '0; // restart from the first entry.
					else if (idx_q == `AR_BITS'(`ARCH_REGS - 1))
						state_q <= RECOVER_IDLE;
					else
						idx_q <= idx_q + 1'b1;
				end
				default:
					state_q <= RECOVER_IDLE;
			endcase
		end
	end

	assign restore = recover; // committed pointer is stable during a walk.
	assign walk_en = (state_q == RECOVER_WALK);
	assign recovering = (state_q == RECOVER_WALK);
	assign walk_idx = idx_q;

endmodule

`default_nettype wire

// ==== rename_defines.svh ====
/*
 * Rename stage sizing.
 * Register counts, tag widths and the number of result-broadcast
 * ports shared by the map table, retired map, free list and the
 * recovery sequencer.
 */

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file.
`define ARCH_REGS 32
`define AR_BITS 5

// physical register file.
`define PHYS_REGS 64
`define PR_BITS 6

// result broadcast ports feeding the ready bits.
`define CDB_PORTS 2

// tags not held by the retired map live in the free queue.
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

// ==== rename_pkg.sv ====
/*
 * Rename stage types.
 * Per-slot request and response words, broadcast and retire words,
 * and the state encoding of the recovery sequencer.
 */

`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

	typedef struct packed {
		logic valid;
		logic [`AR_BITS-1:0] src_a;
		logic use_a; // operand a reads src_a.
		logic [`AR_BITS-1:0] src_b;
		logic use_b; // operand b reads src_b.
		logic [`AR_BITS-1:0] dest;
	} rename_req_t;

	typedef struct packed {
		logic [`PR_BITS-1:0] pr_a;
		logic ready_a;
		logic [`PR_BITS-1:0] pr_b;
		logic ready_b;
		logic [`PR_BITS-1:0] pr_dest; // newly allocated tag.
		logic [`PR_BITS-1:0] pr_told; // previous mapping of dest.
	} rename_resp_t;

	typedef struct packed {
		logic valid;
		logic [`AR_BITS-1:0] ar;
		logic [`PR_BITS-1:0] pr;
	} cdb_t;

	typedef struct packed {
		logic valid;
		logic [`AR_BITS-1:0] ar;
		logic [`PR_BITS-1:0] pr; // committed mapping.
		logic [`PR_BITS-1:0] told; // tag released to the free queue.
	} retire_t;

	typedef enum logic {
		RECOVER_IDLE,
		RECOVER_WALK
	} recover_state_t;

endpackage

`default_nettype wire

// ==== rename_unit.sv ====
/*
 * Register rename stage, two wide.
 * Joins the speculative map table, retired map, free list and the
 * recovery sequencer, and decides when a dispatch group is taken.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_unit
	import rename_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input rename_req_t req [2],
	input cdb_t cdb [`CDB_PORTS],
	input retire_t retire [2],
	input wire logic recover,
	output rename_resp_t resp [2],
	output logic dispatch_ready,
	output logic recovering
);

	logic [`PR_BITS-1:0] free_pr [2];
	logic [`AR_BITS:0] free_count;
	logic [1:0] alloc_count;
	logic accept;

	logic walk_en;
	logic [`AR_BITS-1:0] walk_idx;
	logic [`PR_BITS-1:0] walk_pr;
	logic restore;

	// two tags must be on hand whatever the group size.
	assign dispatch_ready = !recovering && (free_count >= (`AR_BITS+1)'(2));
	assign accept = dispatch_ready && req[0].valid;

	always_comb
	begin
		if (!accept)
			alloc_count = 2'd0;
		else if (req[1].valid)
			alloc_count = 2'd2;
		else
			alloc_count = 2'd1;
	end

	map_table i_map_table (
		.clock(clock),
		.reset(reset),
		.req(req),
		.accept(accept),
		.free_pr(free_pr),
		.cdb(cdb),
		.walk_en(walk_en),
		.walk_idx(walk_idx),
		.walk_pr(walk_pr),
		.resp(resp)
	);

	retire_map i_retire_map (
		.clock(clock),
		.reset(reset),
		.retire(retire),
		.walk_idx(walk_idx),
		.recovering(recovering),
		.walk_pr(walk_pr)
	);

	free_list i_free_list (
		.clock(clock),
		.reset(reset),
		.alloc_count(alloc_count),
		.retire(retire),
		.restore(restore),
		.free_pr(free_pr),
		.free_count(free_count)
	);

	recovery_fsm i_recovery_fsm (
		.clock(clock),
		.reset(reset),
		.recover(recover),
		.walk_en(walk_en),
		.walk_idx(walk_idx),
		.restore(restore),
		.recovering(recovering)
	);

endmodule

`default_nettype wire

// ==== retire_map.sv ====
/*
 * Retired map.
 * Committed architectural-to-physical mapping, identity after reset,
 * written by the retire slots and read one entry per cycle by the
 * recovery walk.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module retire_map
	import rename_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input retire_t retire [2],
	input wire logic [`AR_BITS-1:0] walk_idx,
	input wire logic recovering,
	output logic [`PR_BITS-1:0] walk_pr
);

	logic [`PR_BITS-1:0] rmap_q [`ARCH_REGS];
	logic ret0;
	logic ret1;

	assign ret0 = retire[0].valid;
	assign ret1 = retire[0].valid && retire[1].valid; // slot 1 only with slot 0.

	assign walk_pr = rmap_q[walk_idx];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `ARCH_REGS; i++)
				rmap_q[i] <= `PR_BITS'(i);
		end
		else
		begin
			if (ret0)
				rmap_q[retire[0].ar] <= retire[0].pr;
			if (ret1)
				rmap_q[retire[1].ar] <= retire[1].pr; // younger write wins.
		end
	end

	// a retire mid-walk would leave the map table with a stale entry.
	a_no_retire_in_walk: assert property (
		@(posedge clock) disable iff (reset)
		recovering |-> !(retire[0].valid || retire[1].valid))
		else $error("retire while recovering");

endmodule

`default_nettype wire

// ==== tb_rename_unit.sv ====
/*
 * Testbench for the two-wide rename stage.
 * Directed tests against a model of the speculative map, ready bits,
 * retired map and free queue: allocation order, in-group bypass,
 * broadcast wake-up, back-pressure and misprediction recovery.
 */

`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module tb_rename_unit
	import rename_pkg::*;
();

	logic clock;
	logic reset;
	rename_req_t req [2];
	cdb_t cdb [`CDB_PORTS];
	retire_t retire [2];
	logic recover;
	rename_resp_t resp [2];
	logic dispatch_ready;
	logic recovering;

	int checks;
	int errors;

	// reference model.
	logic [`PR_BITS-1:0] smap [`ARCH_REGS];
	logic [`PR_BITS-1:0] rmap [`ARCH_REGS];
	logic rdy [`ARCH_REGS];
	logic [`PR_BITS-1:0] order [$]; // committed pointer up to write pointer.
	int spec_off; // tags handed out but not yet committed.
	retire_t inflight [$];

	rename_unit i_rename_unit (
		.clock(clock),
		.reset(reset),
		.req(req),
		.cdb(cdb),
		.retire(retire),
		.recover(recover),
		.resp(resp),
		.dispatch_ready(dispatch_ready),
		.recovering(recovering)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < `ARCH_REGS; i++)
		begin
			smap[i] = `PR_BITS'(i);
			rmap[i] = `PR_BITS'(i);
			rdy[i] = 1'b1;
		end
		order.delete();
		for (int i = 0; i < `FREE_DEPTH; i++)
			order.push_back(`PR_BITS'(`ARCH_REGS + i)); // tags 32 to 63.
		spec_off = 0;
		inflight.delete();
	endtask

	function automatic int free_left();
		return order.size() - spec_off;
	endfunction

	function automatic rename_req_t random_request();
		rename_req_t r;
		r.valid = 1'b1;
		r.src_a = `AR_BITS'($urandom);
		r.use_a = 1'($urandom);
		r.src_b = `AR_BITS'($urandom);
		r.use_b = 1'($urandom);
		r.dest = `AR_BITS'($urandom);
		return r;
	endfunction

	// plain table read, no bypass.
	function automatic rename_resp_t lookup(input rename_req_t r);
		rename_resp_t e;
		e.pr_a = smap[r.src_a];
		e.ready_a = !r.use_a || rdy[r.src_a];
		e.pr_b = smap[r.src_b];
		e.ready_b = !r.use_b || rdy[r.src_b];
		e.pr_dest = '0;
		e.pr_told = smap[r.dest];
		return e;
	endfunction

	task automatic compare_resp(input string name, input rename_resp_t e,
		input rename_resp_t a, input bit with_dest);
		compare({name, " pr_a"}, e.pr_a, a.pr_a);
		compare({name, " ready_a"}, e.ready_a, a.ready_a);
		compare({name, " pr_b"}, e.pr_b, a.pr_b);
		compare({name, " ready_b"}, e.ready_b, a.ready_b);
		if (with_dest)
		begin
			compare({name, " pr_dest"}, e.pr_dest, a.pr_dest);
			compare({name, " pr_told"}, e.pr_told, a.pr_told);
		end
	endtask

	task automatic dispatch(input rename_req_t r0, input rename_req_t r1, input string name);
		rename_resp_t e0;
		rename_resp_t e1;
		retire_t entry;
		logic exp_ready;
		exp_ready = free_left() >= 2;
		@(posedge clock);
		req[0] <= r0;
		req[1] <= r1;
		@(negedge clock);
		compare({name, " dispatch_ready"}, exp_ready, dispatch_ready);
		if (exp_ready && r0.valid)
		begin
			e0 = lookup(r0);
			e0.pr_dest = order[spec_off];
			compare_resp({name, " slot0"}, e0, resp[0], 1'b1);
			smap[r0.dest] = e0.pr_dest;
			rdy[r0.dest] = 1'b0;
			entry = '{1'b1, r0.dest, e0.pr_dest, e0.pr_told};
			inflight.push_back(entry);
			spec_off++;
			if (r1.valid)
			begin
				e1 = lookup(r1); // map already holds slot 0's write.
				e1.pr_dest = order[spec_off];
				compare_resp({name, " slot1"}, e1, resp[1], 1'b1);
				smap[r1.dest] = e1.pr_dest;
				rdy[r1.dest] = 1'b0;
				entry = '{1'b1, r1.dest, e1.pr_dest, e1.pr_told};
				inflight.push_back(entry);
				spec_off++;
			end
		end
		@(posedge clock);
		req[0] <= '0;
		req[1] <= '0;
	endtask

	// read two registers without allocating.
	task automatic probe(input logic [`AR_BITS-1:0] a, input logic [`AR_BITS-1:0] b,
		input string name);
		rename_req_t r;
		r = '0;
		r.src_a = a;
		r.use_a = 1'b1;
		r.src_b = b;
		r.use_b = 1'b1;
		@(posedge clock);
		req[0] <= r;
		@(negedge clock);
		compare_resp(name, lookup(r), resp[0], 1'b0);
		@(posedge clock);
		req[0] <= '0;
	endtask

	task automatic broadcast(input int port, input logic [`AR_BITS-1:0] ar,
		input logic [`PR_BITS-1:0] pr, input string name);
		cdb_t c;
		rename_req_t r;
		c.valid = 1'b1;
		c.ar = ar;
		c.pr = pr;
		r = '0;
		r.src_a = ar;
		r.use_a = 1'b1;
		@(posedge clock);
		cdb[port] <= c;
		req[0] <= r;
		@(negedge clock);
		compare_resp({name, " same cycle"}, lookup(r), resp[0], 1'b0); // no bypass.
		if (smap[ar] == pr)
			rdy[ar] = 1'b1;
		@(posedge clock);
		cdb[port] <= '0;
		@(negedge clock);
		compare_resp({name, " next cycle"}, lookup(r), resp[0], 1'b0);
		@(posedge clock);
		req[0] <= '0;
	endtask

	task automatic retire_oldest(input int count);
		retire_t r0;
		retire_t r1;
		r0 = '0;
		r1 = '0;
		if (inflight.size() > 0 && count > 0)
			r0 = inflight.pop_front();
		if (inflight.size() > 0 && count > 1)
			r1 = inflight.pop_front();
		@(posedge clock);
		retire[0] <= r0;
		retire[1] <= r1;
		@(posedge clock);
		retire[0] <= '0;
		retire[1] <= '0;
		if (r0.valid)
		begin
			rmap[r0.ar] = r0.pr;
			order.push_back(r0.told);
			void'(order.pop_front());
			spec_off--;
		end
		if (r1.valid)
		begin
			rmap[r1.ar] = r1.pr;
			order.push_back(r1.told);
			void'(order.pop_front());
			spec_off--;
		end
	endtask

	task automatic wait_dispatch_ready(input string name);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!dispatch_ready && cycles < 50)
		begin
			cycles++;
			@(negedge clock);
		end
		if (!dispatch_ready)
		begin
			errors++;
			$display("%s: timed out waiting for dispatch_ready", name);
		end
	endtask

	task automatic recover_walk(input string name);
		int cycles;
		@(posedge clock);
		recover <= 1'b1;
		@(posedge clock);
		recover <= 1'b0;
		for (int i = 0; i < `ARCH_REGS; i++)
		begin
			smap[i] = rmap[i];
			rdy[i] = 1'b1;
		end
		spec_off = 0; // squashed tags are free again.
		inflight.delete();
		cycles = 0;
		@(negedge clock);
		compare({name, " dispatch_ready in walk"}, 0, dispatch_ready);
		while (recovering && cycles < 100)
		begin
			cycles++;
			@(negedge clock);
		end
		if (recovering)
		begin
			errors++;
			$display("%s: timed out waiting for recovering to fall", name);
		end
		compare({name, " walk cycles"}, `ARCH_REGS, cycles);
		compare({name, " dispatch_ready after walk"}, 1, dispatch_ready);
	endtask

	task automatic reset_allocation();
		for (int i = 0; i < 4; i++)
			dispatch(random_request(), '0, "reset_allocation");
	endtask

	task automatic group_bypass();
		rename_req_t r0;
		rename_req_t r1;
		r0 = '0;
		r0.valid = 1'b1;
		r0.src_a = 5'd1;
		r0.use_a = 1'b1;
		r0.dest = 5'd5;
		r1 = '0;
		r1.valid = 1'b1;
		r1.src_a = 5'd5;
		r1.use_a = 1'b1;
		r1.src_b = 5'd5;
		r1.use_b = 1'b1;
		r1.dest = 5'd7;
		dispatch(r0, r1, "group_bypass source");
		r0.dest = 5'd9;
		r1.src_a = 5'd2;
		r1.src_b = 5'd3;
		r1.dest = 5'd9;
		dispatch(r0, r1, "group_bypass same dest");
		probe(5'd9, 5'd7, "group_bypass later read");
	endtask

	task automatic wakeup_by_broadcast();
		rename_req_t r0;
		logic [`PR_BITS-1:0] tag;
		r0 = '0;
		r0.valid = 1'b1;
		r0.dest = 5'd3;
		tag = order[spec_off];
		dispatch(r0, '0, "wakeup alloc");
		broadcast(0, 5'd3, tag, "wakeup current");
		dispatch(r0, '0, "wakeup remap");
		broadcast(1, 5'd3, tag, "wakeup stale"); // old tag must not wake r3.
	endtask

	task automatic dispatch_backpressure();
		rename_req_t r0;
		rename_req_t r1;
		int n;
		n = 0;
		// leave one tag behind so the held state sits just below two.
		while (free_left() >= 2 && n < 40)
		begin
			if (free_left() == 2)
				dispatch(random_request(), '0, "backpressure fill");
			else
				dispatch(random_request(), random_request(), "backpressure fill");
			n++;
		end
		r0 = random_request();
		r1 = random_request();
		dispatch(r0, r1, "backpressure held");
		probe(r0.dest, r1.dest, "backpressure unchanged");
		retire_oldest(2);
		dispatch(random_request(), random_request(), "backpressure reuse");
	endtask

	task automatic misprediction_recovery();
		retire_oldest(2);
		retire_oldest(2);
		for (int i = 0; i < 3; i++)
			if (free_left() >= 2)
				dispatch(random_request(), random_request(), "recovery fill");
		retire_oldest(1);
		recover_walk("recovery");
		for (int a = 0; a < `ARCH_REGS; a += 2)
			probe(`AR_BITS'(a), `AR_BITS'(a + 1), "recovery map");
		dispatch(random_request(), random_request(), "recovery alloc");
	endtask

	initial
	begin
		void'($urandom(32'hf035d917));
		checks = 0;
		errors = 0;
		reset <= 1'b1;
		recover <= 1'b0;
		req[0] <= '0;
		req[1] <= '0;
		cdb[0] <= '0;
		cdb[1] <= '0;
		retire[0] <= '0;
		retire[1] <= '0;
		reset_model();
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		wait_dispatch_ready("reset");
		reset_allocation();
		group_bypass();
		wakeup_by_broadcast();
		dispatch_backpressure();
		misprediction_recovery();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
